// ==== Bender.yml ====
package:
  name: l1i_cache

sources:
  - src/l1i_pkg.sv
  - src/icache_array.sv
  - src/icache_miss_ctrl.sv
  - src/icache.sv
  - src/icache_wrapper.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_icache.sv

// ==== l1i_cache.f ====
src/l1i_pkg.sv
src/icache_array.sv
src/icache_miss_ctrl.sv
src/icache.sv
src/icache_wrapper.sv
tb/tb_clock_gen.sv
tb/tb_icache.sv

// ==== src/icache.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------
// icache core, tracks which set the core feedback refers to,
// does the snoop tag compare and ties array and miss logic
// ----------------------------------------------------------

module icache (
	input  logic CLK,
	input  logic nRST,

	input  l1i_pkg::core_req_t core_req,
	output l1i_pkg::core_resp_t core_resp,
	input  l1i_pkg::core_fb_t core_fb,

	output l1i_pkg::l2_req_t l2_req,
	input  logic l2_req_ready,
	input  l1i_pkg::l2_resp_t l2_resp,

	input  l1i_pkg::snoop_t snoop
);

	// request tracking
	logic rd_valid_q;
	logic [l1i_pkg::INDEX_WIDTH-1:0] rd_index_q;
	logic [l1i_pkg::INDEX_WIDTH-1:0] resp_index_q;
	logic [l1i_pkg::INDEX_WIDTH-1:0] fb_index_q;

	l1i_pkg::core_resp_t rd_resp;

	// fill bus
	logic fill_en;
	logic [l1i_pkg::INDEX_WIDTH-1:0] fill_index;
	logic fill_way;
	logic [l1i_pkg::TAG_WIDTH-1:0] fill_tag;
	logic [l1i_pkg::BLOCK_BITS-1:0] fill_data;

	logic [l1i_pkg::INDEX_WIDTH-1:0] lru_index;
	logic lru_way;

	// snoop
	logic [l1i_pkg::INDEX_WIDTH-1:0] snoop_index;
	logic [l1i_pkg::TAG_WIDTH-1:0] snoop_tag;
	logic [l1i_pkg::ASSOC-1:0][l1i_pkg::TAG_WIDTH-1:0] snoop_tags;
	logic [l1i_pkg::ASSOC-1:0] inv_way_mask;

	// ----------------------------------------------------------
	// index pipeline
	// rd stage lines up with the array output, resp with the wrapper
	// output, fb with the feedback that answers it
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rd_valid_q <= 1'b0;
			rd_index_q <= '0;
			resp_index_q <= '0;
			fb_index_q <= '0;
		end else begin
			rd_valid_q <= core_req.valid;
			rd_index_q <= core_req.index;
			resp_index_q <= rd_index_q;
			fb_index_q <= resp_index_q;
		end
	end

	// no request, no valid ways
	always_comb begin
		core_resp = rd_resp;
		core_resp.valid_by_way = rd_resp.valid_by_way & {l1i_pkg::ASSOC{rd_valid_q}};
	end

	// ----------------------------------------------------------
	// snoop lookup
	assign snoop_index = snoop.block_addr[l1i_pkg::INDEX_WIDTH-1:0];
	assign snoop_tag = snoop.block_addr[l1i_pkg::BLOCK_ADDR_WIDTH-1:l1i_pkg::INDEX_WIDTH];

	always_comb begin
		for (int w = 0; w < l1i_pkg::ASSOC; w++) begin
			inv_way_mask[w] = snoop.valid && (snoop_tags[w] == snoop_tag);
			// also catch the line being filled right now
			if (snoop.valid && fill_en && (fill_index == snoop_index) &&
				(fill_tag == snoop_tag) && (int'(fill_way) == w)) begin
				inv_way_mask[w] = 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// submodules
	icache_array u_array (
		.CLK(CLK),
		.nRST(nRST),
		.rd_index(core_req.index),
		.rd_ofs(core_req.ofs),
		.rd_resp(rd_resp),
		.fill_en(fill_en),
		.fill_index(fill_index),
		.fill_way(fill_way),
		.fill_tag(fill_tag),
		.fill_data(fill_data),
		.inv_en(snoop.valid),
		.inv_index(snoop_index),
		.inv_way_mask(inv_way_mask),
		.lru_touch_en(core_fb.hit_valid),
		.lru_touch_index(fb_index_q),
		.lru_touch_way(core_fb.hit_way),
		.lru_index(lru_index),
		.lru_way(lru_way),
		.snoop_tags(snoop_tags)
	);

	icache_miss_ctrl u_miss_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.miss_valid(core_fb.miss_valid),
		.miss_tag(core_fb.miss_tag),
		.miss_index(fb_index_q),
		.l2_req(l2_req),
		.l2_req_ready(l2_req_ready),
		.l2_resp(l2_resp),
		.lru_way(lru_way),
		.lru_index(lru_index),
		.fill_en(fill_en),
		.fill_index(fill_index),
		.fill_way(fill_way),
		.fill_tag(fill_tag),
		.fill_data(fill_data)
	);

endmodule

`default_nettype wire

// ==== src/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------
// tag, valid and LRU state plus the data RAM of the icache,
// read one cycle after the index is presented
// ----------------------------------------------------------

module icache_array (
	input  logic CLK,
	input  logic nRST,

	// read port
	input  logic [l1i_pkg::INDEX_WIDTH-1:0] rd_index,
	input  logic [l1i_pkg::FETCH_OFS_WIDTH-1:0] rd_ofs,
	output l1i_pkg::core_resp_t rd_resp,

	// fill from miss control
	input  logic fill_en,
	input  logic [l1i_pkg::INDEX_WIDTH-1:0] fill_index,
	input  logic fill_way,
	input  logic [l1i_pkg::TAG_WIDTH-1:0] fill_tag,
	input  logic [l1i_pkg::BLOCK_BITS-1:0] fill_data,

	// snoop clear
	input  logic inv_en,
	input  logic [l1i_pkg::INDEX_WIDTH-1:0] inv_index,
	input  logic [l1i_pkg::ASSOC-1:0] inv_way_mask,

	// LRU update and lookup
	input  logic lru_touch_en,
	input  logic [l1i_pkg::INDEX_WIDTH-1:0] lru_touch_index,
	input  logic lru_touch_way,
	input  logic [l1i_pkg::INDEX_WIDTH-1:0] lru_index,
	output logic lru_way,

	output logic [l1i_pkg::ASSOC-1:0][l1i_pkg::TAG_WIDTH-1:0] snoop_tags
);

	logic [l1i_pkg::NUM_SETS-1:0][l1i_pkg::ASSOC-1:0] valid_q;
	logic [l1i_pkg::NUM_SETS-1:0][l1i_pkg::ASSOC-1:0][l1i_pkg::TAG_WIDTH-1:0] tag_q;
	// per set, the way to replace next
	logic [l1i_pkg::NUM_SETS-1:0] lru_q;
	logic [l1i_pkg::BLOCK_BITS-1:0] data_ram [l1i_pkg::ASSOC][l1i_pkg::NUM_SETS];

	logic [l1i_pkg::ASSOC-1:0] resp_valid_q;
	logic [l1i_pkg::ASSOC-1:0][l1i_pkg::TAG_WIDTH-1:0] resp_tag_q;
	logic [l1i_pkg::ASSOC-1:0][l1i_pkg::FETCH_WIDTH-1:0][7:0] resp_instr_q;

	// ----------------------------------------------------------
	// tag and valid flops
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			tag_q <= '0;
		end else begin
			if (fill_en) begin
				valid_q[fill_index][fill_way] <= 1'b1;
				tag_q[fill_index][fill_way] <= fill_tag;
			end
			// clear comes last so a snoop beats a fill to the same line
			for (int w = 0; w < l1i_pkg::ASSOC; w++) begin
				if (inv_en && inv_way_mask[w]) begin
					valid_q[inv_index][w] <= 1'b0;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// LRU bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru_q <= '0;
		end else begin
			if (lru_touch_en) begin
				lru_q[lru_touch_index] <= ~lru_touch_way;
			end
			// newly filled way is the most recent
			if (fill_en) begin
				lru_q[fill_index] <= ~fill_way;
			end
		end
	end

	assign lru_way = lru_q[lru_index];
	assign snoop_tags = tag_q[inv_index];

	// ----------------------------------------------------------
	// data RAM
	always_ff @(posedge CLK) begin
		if (fill_en) begin
			data_ram[fill_way][fill_index] <= fill_data;
		end
	end

	// pick the requested fetch half of each way
	always_ff @(posedge CLK) begin
		for (int w = 0; w < l1i_pkg::ASSOC; w++) begin
			resp_instr_q[w] <= data_ram[w][rd_index][rd_ofs * l1i_pkg::FETCH_WIDTH * 8 +:
				l1i_pkg::FETCH_WIDTH * 8];
		end
	end

	// tags and valids travel with the data
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			resp_valid_q <= '0;
			resp_tag_q <= '0;
		end else begin
			resp_valid_q <= valid_q[rd_index];
			resp_tag_q <= tag_q[rd_index];
		end
	end

	always_comb begin
		rd_resp.valid_by_way = resp_valid_q;
		rd_resp.tag_by_way = resp_tag_q;
		rd_resp.instr_by_way = resp_instr_q;
	end

endmodule

`default_nettype wire

// ==== src/icache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------
// single outstanding miss, the L2 block request and the fill
// ----------------------------------------------------------

module icache_miss_ctrl (
	input  logic CLK,
	input  logic nRST,

	// miss from core feedback
	input  logic miss_valid,
	input  logic [l1i_pkg::TAG_WIDTH-1:0] miss_tag,
	input  logic [l1i_pkg::INDEX_WIDTH-1:0] miss_index,

	// L2 request and response
	output l1i_pkg::l2_req_t l2_req,
	input  logic l2_req_ready,
	input  l1i_pkg::l2_resp_t l2_resp,

	// replacement way of the pending set
	input  logic lru_way,
	output logic [l1i_pkg::INDEX_WIDTH-1:0] lru_index,

	// fill into the array
	output logic fill_en,
	output logic [l1i_pkg::INDEX_WIDTH-1:0] fill_index,
	output logic fill_way,
	output logic [l1i_pkg::TAG_WIDTH-1:0] fill_tag,
	output logic [l1i_pkg::BLOCK_BITS-1:0] fill_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t state_q;
	state_t state_d;
	// {tag, index} of the pending miss
	logic [l1i_pkg::BLOCK_ADDR_WIDTH-1:0] pend_addr_q;
	logic resp_match;

	// responses for other blocks are ignored
	assign resp_match = (state_q == ST_WAIT) && l2_resp.valid &&
		(l2_resp.block_addr == pend_addr_q);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (miss_valid) state_d = ST_REQ;
			ST_REQ: if (l2_req_ready) state_d = ST_WAIT;
			ST_WAIT: if (resp_match) state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= ST_IDLE;
			pend_addr_q <= '0;
		end else begin
			state_q <= state_d;
			// misses while busy are dropped
			if (state_q == ST_IDLE && miss_valid) begin
				pend_addr_q <= {miss_tag, miss_index};
			end
		end
	end

	// ----------------------------------------------------------
	// outputs
	always_comb begin
		l2_req.valid = (state_q == ST_REQ);
		l2_req.block_addr = pend_addr_q;
	end

	assign lru_index = pend_addr_q[l1i_pkg::INDEX_WIDTH-1:0];

	// way is chosen when the data arrives, not when the miss came in
	assign fill_en = resp_match;
	assign fill_index = lru_index;
	assign fill_way = lru_way;
	assign fill_tag = pend_addr_q[l1i_pkg::BLOCK_ADDR_WIDTH-1:l1i_pkg::INDEX_WIDTH];
	assign fill_data = l2_resp.data;

endmodule

`default_nettype wire

// ==== src/icache_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------
// top level, one register stage on every icache port so the
// cache can sit inside a larger core without timing trouble
// ----------------------------------------------------------

module icache_wrapper (
	input  logic CLK,
	input  logic nRST,

	// core request and response
	input  l1i_pkg::core_req_t next_core_req,
	output l1i_pkg::core_resp_t last_core_resp,

	// core feedback
	input  l1i_pkg::core_fb_t next_core_fb,

	// L2
	output l1i_pkg::l2_req_t last_l2_req,
	input  logic next_l2_req_ready,
	input  l1i_pkg::l2_resp_t next_l2_resp,

	// snoop invalidate
	input  l1i_pkg::snoop_t next_snoop
);

	// ----------------------------------------------------------
	// cache side of the registers
	l1i_pkg::core_req_t core_req;
	l1i_pkg::core_resp_t core_resp;
	l1i_pkg::core_fb_t core_fb;
	l1i_pkg::l2_req_t l2_req;
	logic l2_req_ready;
	l1i_pkg::l2_resp_t l2_resp;
	l1i_pkg::snoop_t snoop;

	icache u_icache (
		.CLK(CLK),
		.nRST(nRST),
		.core_req(core_req),
		.core_resp(core_resp),
		.core_fb(core_fb),
		.l2_req(l2_req),
		.l2_req_ready(l2_req_ready),
		.l2_resp(l2_resp),
		.snoop(snoop)
	);

	// ----------------------------------------------------------
	// port registers
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// inbound
			core_req <= '0;
			core_fb <= '0;
			l2_req_ready <= 1'b0;
			l2_resp <= '0;
			snoop <= '0;
			// outbound
			last_core_resp <= '0;
			last_l2_req <= '0;
		end else begin
			core_req <= next_core_req;
			core_fb <= next_core_fb;
			l2_req_ready <= next_l2_req_ready;
			l2_resp <= next_l2_resp;
			snoop <= next_snoop;
			last_core_resp <= core_resp;
			last_l2_req <= l2_req;
		end
	end

endmodule

`default_nettype wire

// ==== src/l1i_pkg.sv ====
`default_nettype none
// ----------------------------------------------------------
// L1 instruction cache geometry and the packed structs that
// carry core, L2 and snoop traffic between the cache blocks
// ----------------------------------------------------------

package l1i_pkg;

	// ----------------------------------------------------------
	// geometry
	localparam int unsigned PA_WIDTH = 22;
	localparam int unsigned BLOCK_SIZE = 32;
	localparam int unsigned FETCH_WIDTH = 16;
	localparam int unsigned ASSOC = 2;
	localparam int unsigned NUM_SETS = 16;
	localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
	localparam int unsigned OFFSET_WIDTH = $clog2(BLOCK_SIZE);
	localparam int unsigned FETCH_OFS_WIDTH = $clog2(BLOCK_SIZE / FETCH_WIDTH);
	localparam int unsigned TAG_WIDTH = PA_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int unsigned BLOCK_ADDR_WIDTH = TAG_WIDTH + INDEX_WIDTH;
	localparam int unsigned BLOCK_BITS = BLOCK_SIZE * 8;

	// ----------------------------------------------------------
	// core side
	typedef struct packed {
		logic valid;
		logic [FETCH_OFS_WIDTH-1:0] ofs;
		logic [INDEX_WIDTH-1:0] index;
	} core_req_t;

	typedef struct packed {
		logic [ASSOC-1:0] valid_by_way;
		logic [ASSOC-1:0][TAG_WIDTH-1:0] tag_by_way;
		logic [ASSOC-1:0][FETCH_WIDTH-1:0][7:0] instr_by_way;
	} core_resp_t;

	// tag compare result reported back by the core
	typedef struct packed {
		logic hit_valid;
		logic hit_way;
		logic miss_valid;
		logic [TAG_WIDTH-1:0] miss_tag;
	} core_fb_t;

	// ----------------------------------------------------------
	// L2 side
	typedef struct packed {
		logic valid;
		logic [BLOCK_ADDR_WIDTH-1:0] block_addr;
	} l2_req_t;

	typedef struct packed {
		logic valid;
		logic [BLOCK_ADDR_WIDTH-1:0] block_addr;
		logic [BLOCK_BITS-1:0] data;
	} l2_resp_t;

	typedef struct packed {
		logic valid;
		logic [BLOCK_ADDR_WIDTH-1:0] block_addr;
	} snoop_t;

endpackage

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------
// testbench clock, 4 ns period, reset low for 4 cycles
// ----------------------------------------------------------

module tb_clock_gen (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		nRST = 1'b0;
		repeat (4) @(posedge CLK);
		#1 nRST = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------
// icache wrapper testbench, a shadow cache model predicts every
// response and L2 request, an L2 model answers the misses
// ----------------------------------------------------------

module tb_icache;

	typedef enum logic [1:0] {M_IDLE, M_REQ, M_WAIT} mstate_t;

	logic CLK;
	logic nRST;
	l1i_pkg::core_req_t next_core_req;
	l1i_pkg::core_resp_t last_core_resp;
	l1i_pkg::core_fb_t next_core_fb;
	l1i_pkg::l2_req_t last_l2_req;
	logic next_l2_req_ready;
	l1i_pkg::l2_resp_t next_l2_resp;
	l1i_pkg::snoop_t next_snoop;

	// shadow cache state
	logic [l1i_pkg::ASSOC-1:0] m_valid [l1i_pkg::NUM_SETS];
	logic [l1i_pkg::TAG_WIDTH-1:0] m_tag [l1i_pkg::NUM_SETS][l1i_pkg::ASSOC];
	logic m_lru [l1i_pkg::NUM_SETS];
	mstate_t m_state;
	logic [l1i_pkg::BLOCK_ADDR_WIDTH-1:0] m_pend;
	logic [l1i_pkg::INDEX_WIDTH-1:0] rd_idx, resp_idx, fb_idx;
	// inputs as seen inside the wrapper
	l1i_pkg::core_req_t r_req;
	l1i_pkg::core_fb_t r_fb;
	logic r_ready;
	l1i_pkg::l2_resp_t r_resp;
	l1i_pkg::snoop_t r_snoop;
	l1i_pkg::core_resp_t stage_resp, exp_resp;
	l1i_pkg::l2_req_t exp_l2;

	string test_name = "reset";
	int seed = 30140;
	int resp_seed = 30140;
	logic bp_long = 1'b0;

	tb_clock_gen u_clk (.CLK(CLK), .nRST(nRST));

	icache_wrapper DUT (
		.CLK(CLK),
		.nRST(nRST),
		.next_core_req(next_core_req),
		.last_core_resp(last_core_resp),
		.next_core_fb(next_core_fb),
		.last_l2_req(last_l2_req),
		.next_l2_req_ready(next_l2_req_ready),
		.next_l2_resp(next_l2_resp),
		.next_snoop(next_snoop)
	);

	// block contents depend on every address bit
	function automatic logic [l1i_pkg::BLOCK_BITS-1:0] block_data(
		input logic [l1i_pkg::BLOCK_ADDR_WIDTH-1:0] addr);
		logic [l1i_pkg::BLOCK_BITS-1:0] d;
		for (int i = 0; i < 8; i++) begin
			d[i*32 +: 32] = {addr, 3'(i), 12'h5c3};
		end
		return d;
	endfunction

	// expected array output for one read, from the shadow state
	function automatic l1i_pkg::core_resp_t expect_read(
		input logic [l1i_pkg::INDEX_WIDTH-1:0] idx, input logic ofs, input logic req_valid);
		l1i_pkg::core_resp_t r;
		logic [l1i_pkg::BLOCK_BITS-1:0] blk;
		r = '0;
		for (int w = 0; w < l1i_pkg::ASSOC; w++) begin
			r.valid_by_way[w] = m_valid[idx][w] & req_valid;
			r.tag_by_way[w] = m_tag[idx][w];
			blk = block_data({m_tag[idx][w], idx});
			if (r.valid_by_way[w]) begin
				r.instr_by_way[w] = blk[ofs*128 +: 128];
			end
		end
		return r;
	endfunction

	// ----------------------------------------------------------
	// shadow model, one step per clock edge
	always @(posedge CLK or negedge nRST) begin : shadow_model
		logic fill_hit;
		logic fw;
		logic [l1i_pkg::INDEX_WIDTH-1:0] pidx, sidx;
		logic [l1i_pkg::TAG_WIDTH-1:0] stag;
		logic [l1i_pkg::TAG_WIDTH-1:0] old_tags [l1i_pkg::ASSOC];
		if (!nRST) begin
			for (int s = 0; s < l1i_pkg::NUM_SETS; s++) begin
				m_valid[s] = '0;
				m_tag[s][0] = '0;
				m_tag[s][1] = '0;
				m_lru[s] = 1'b0;
			end
			m_state = M_IDLE;
			m_pend = '0;
			{rd_idx, resp_idx, fb_idx} = '0;
			{r_req, r_fb, r_ready, r_resp, r_snoop} = '0;
			stage_resp = '0;
			exp_resp = '0;
			exp_l2 = '0;
		end else begin
			exp_l2.valid = (m_state == M_REQ);
			exp_l2.block_addr = m_pend;
			exp_resp = stage_resp;
			stage_resp = expect_read(r_req.index, r_req.ofs, r_req.valid);
			pidx = m_pend[l1i_pkg::INDEX_WIDTH-1:0];
			fw = m_lru[pidx];
			sidx = r_snoop.block_addr[l1i_pkg::INDEX_WIDTH-1:0];
			stag = r_snoop.block_addr[l1i_pkg::BLOCK_ADDR_WIDTH-1:l1i_pkg::INDEX_WIDTH];
			old_tags[0] = m_tag[sidx][0];
			old_tags[1] = m_tag[sidx][1];
			fill_hit = (m_state == M_WAIT) && r_resp.valid && (r_resp.block_addr == m_pend);
			if (r_fb.hit_valid) begin
				m_lru[fb_idx] = ~r_fb.hit_way;
			end
			case (m_state)
				M_IDLE: if (r_fb.miss_valid) begin
					m_pend = {r_fb.miss_tag, fb_idx};
					m_state = M_REQ;
				end
				M_REQ: if (r_ready) m_state = M_WAIT;
				default: if (fill_hit) m_state = M_IDLE;
			endcase
			if (fill_hit) begin
				m_valid[pidx][fw] = 1'b1;
				m_tag[pidx][fw] = m_pend[l1i_pkg::BLOCK_ADDR_WIDTH-1:l1i_pkg::INDEX_WIDTH];
				m_lru[pidx] = ~fw;
			end
			// snoop wins over a fill of the same line
			for (int w = 0; w < l1i_pkg::ASSOC; w++) begin
				if (r_snoop.valid && (old_tags[w] == stag || (fill_hit && pidx == sidx &&
					int'(fw) == w && m_pend[l1i_pkg::BLOCK_ADDR_WIDTH-1:4] == stag))) begin
					m_valid[sidx][w] = 1'b0;
				end
			end
			fb_idx = resp_idx;
			resp_idx = rd_idx;
			rd_idx = r_req.index;
			r_req = next_core_req;
			r_fb = next_core_fb;
			r_ready = next_l2_req_ready;
			r_resp = next_l2_resp;
			r_snoop = next_snoop;
		end
	end

	// ----------------------------------------------------------
	// checker, mid cycle when outputs are stable
	always @(negedge CLK) begin : compare
		l1i_pkg::core_resp_t act;
		if (nRST) begin
			act = last_core_resp;
			for (int w = 0; w < l1i_pkg::ASSOC; w++) begin
				if (act.valid_by_way[w] !== 1'b1) act.instr_by_way[w] = '0;
			end
			assert (act === exp_resp) else begin
				$display("mismatch %s core_resp expected %h actual %h", test_name, exp_resp, act);
				$display("** FAIL **");
				$fatal(1, "core response differs from the model");
			end
			assert (last_l2_req === exp_l2) else begin
				$display("mismatch %s l2_req expected %h actual %h", test_name, exp_l2,
					last_l2_req);
				$display("** FAIL **");
				$fatal(1, "L2 request differs from the model");
			end
		end
	end

	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	// ----------------------------------------------------------
	// L2 model with random accept delay and fill latency
	initial begin : l2_responder
		logic [l1i_pkg::BLOCK_ADDR_WIDTH-1:0] addr;
		int hold;
		int cnt;
		next_l2_req_ready = 1'b0;
		next_l2_resp = '0;
		forever begin
			tick();
			if (nRST && last_l2_req.valid) begin
				addr = last_l2_req.block_addr;
				hold = $unsigned($random(resp_seed)) % (bp_long ? 13 : 4);
				repeat (hold) tick();
				next_l2_req_ready = 1'b1;
				cnt = 0;
				while (last_l2_req.valid) begin
					tick();
					cnt++;
					if (cnt > 50) begin
						$display("L2 request was never dropped after ready was given");
						$display("** FAIL **");
						$fatal(1);
					end
				end
				next_l2_req_ready = 1'b0;
				repeat ($unsigned($random(resp_seed)) % 4) tick();
				// unrelated block first, must be ignored
				next_l2_resp.valid = 1'b1;
				next_l2_resp.block_addr = addr ^ 17'h1;
				next_l2_resp.data = block_data(addr ^ 17'h1);
				tick();
				next_l2_resp.block_addr = addr;
				next_l2_resp.data = block_data(addr);
				tick();
				next_l2_resp = '0;
			end
		end
	end

	// ----------------------------------------------------------
	// stimulus helpers
	task automatic read_set(input logic [3:0] idx, input logic ofs);
		next_core_req.valid = 1'b1;
		next_core_req.ofs = ofs;
		next_core_req.index = idx;
		tick();
		next_core_req = '0;
	endtask

	// read a set, then answer its response with hit or miss
	task automatic send_fb(input logic [3:0] idx, input logic hit, input logic way,
		input logic miss, input logic [12:0] tag);
		read_set(idx, 1'b0);
		tick();
		tick();
		next_core_fb.hit_valid = hit;
		next_core_fb.hit_way = way;
		next_core_fb.miss_valid = miss;
		next_core_fb.miss_tag = tag;
		tick();
		next_core_fb = '0;
	endtask

	task automatic wait_idle();
		int cnt;
		cnt = 0;
		// feedback sent last cycle reaches the miss logic at the next edge
		tick();
		while (m_state != M_IDLE) begin
			tick();
			cnt++;
			if (cnt > 300) begin
				$display("timeout waiting for the pending miss to be filled in %s", test_name);
				$display("** FAIL **");
				$fatal(1);
			end
		end
		repeat (3) tick();
	endtask

	task automatic read_both(input logic [3:0] idx);
		read_set(idx, 1'b0);
		read_set(idx, 1'b1);
		repeat (3) tick();
	endtask

	initial begin : main
		int cnt;
		logic hw;
		next_core_req = '0;
		next_core_fb = '0;
		next_snoop = '0;
		cnt = 0;
		while (!nRST) begin
			#1;
			cnt++;
			if (cnt > 100) begin
				$display("reset was never released");
				$display("** FAIL **");
				$fatal(1);
			end
		end
		tick();
		for (int s = 0; s < l1i_pkg::NUM_SETS; s++) read_set(4'(s), 1'(s));
		repeat (4) tick();

		test_name = "cold_miss";
		send_fb(4'd5, 1'b0, 1'b0, 1'b1, 13'h0a1);
		wait_idle();
		read_both(4'd5);

		test_name = "replacement";
		send_fb(4'd5, 1'b0, 1'b0, 1'b1, 13'h0b2);
		wait_idle();
		read_both(4'd5);
		hw = (m_tag[5][1] == 13'h0a1);
		send_fb(4'd5, 1'b1, hw, 1'b0, 13'h0);
		send_fb(4'd5, 1'b0, 1'b0, 1'b1, 13'h0c3);
		wait_idle();
		read_both(4'd5);

		test_name = "back_pressure";
		bp_long = 1'b1;
		send_fb(4'd9, 1'b0, 1'b0, 1'b1, 13'h1d4);
		send_fb(4'd9, 1'b0, 1'b0, 1'b1, 13'h1e5);
		send_fb(4'd3, 1'b0, 1'b0, 1'b1, 13'h1f6);
		wait_idle();
		read_both(4'd9);
		read_both(4'd3);
		bp_long = 1'b0;

		test_name = "snoop";
		next_snoop.valid = 1'b1;
		next_snoop.block_addr = {13'h0a1, 4'd5};
		tick();
		next_snoop.block_addr = {13'h1d4, 4'd5};
		tick();
		next_snoop = '0;
		read_both(4'd5);
		read_both(4'd9);

		// snoop a block in the same cycle that its fill is written
		send_fb(4'd7, 1'b0, 1'b0, 1'b1, 13'h0e7);
		cnt = 0;
		@(posedge CLK);
		// the unrelated block goes out one cycle before the real fill
		while (!(next_l2_resp.valid && next_l2_resp.block_addr == {13'h0e7, 4'd6})) begin
			@(posedge CLK);
			cnt++;
			if (cnt > 300) begin
				$display("timeout waiting for the L2 fill in %s", test_name);
				$display("** FAIL **");
				$fatal(1);
			end
		end
		#1;
		next_snoop.valid = 1'b1;
		next_snoop.block_addr = {13'h0e7, 4'd7};
		tick();
		next_snoop = '0;
		wait_idle();
		read_both(4'd7);

		test_name = "random_mix";
		for (int c = 0; c < 2000; c++) begin
			next_core_req.valid = ($unsigned($random(seed)) % 10) < 7;
			next_core_req.ofs = $random(seed);
			next_core_req.index = $random(seed);
			next_core_fb.hit_valid = ($unsigned($random(seed)) % 4) == 0;
			next_core_fb.hit_way = $random(seed);
			next_core_fb.miss_valid = ($unsigned($random(seed)) % 8) == 0;
			next_core_fb.miss_tag = 13'h100 + ($unsigned($random(seed)) % 4);
			next_snoop.valid = ($unsigned($random(seed)) % 20) == 0;
			next_snoop.block_addr = {13'h100 + 13'($unsigned($random(seed)) % 4),
				4'($random(seed))};
			tick();
		end
		next_core_req = '0;
		next_core_fb = '0;
		next_snoop = '0;
		wait_idle();
		for (int s = 0; s < l1i_pkg::NUM_SETS; s++) read_both(4'(s));
		repeat (4) tick();

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
